//--- Makefile
TOP = tb_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- core.sv
module core #(
	parameter logic [core_pkg::xlen-1:0] RESET_PC = core_pkg::default_reset_pc
) (
	input  logic clk,
	input  logic reset,
	output logic ireq_valid,
	output logic [core_pkg::xlen-1:0] ireq_addr,
	input  logic iresp_data_ok,
	input  logic [core_pkg::ilen-1:0] iresp_data,
	output logic commit_valid,
	output logic [core_pkg::xlen-1:0] commit_pc,
	output logic [core_pkg::ilen-1:0] commit_instr,
	output logic commit_wen,
	output logic [core_pkg::reg_addr_w-1:0] commit_wdest,
	output logic [core_pkg::xlen-1:0] commit_wdata
);
	import core_pkg::*;

	logic f_valid;
	logic [xlen-1:0] f_pc;
	logic [ilen-1:0] f_instr;

	logic d_valid;
	logic [xlen-1:0] d_pc;
	logic [ilen-1:0] d_instr;
	alu_op_t d_alu_op;
	logic [xlen-1:0] d_a;
	logic [xlen-1:0] d_b;
	logic d_wen;
	logic [reg_addr_w-1:0] d_wdest;

	logic e_valid;
	logic [xlen-1:0] e_pc;
	logic [ilen-1:0] e_instr;
	logic e_wen;
	logic [reg_addr_w-1:0] e_wdest;
	logic [xlen-1:0] e_result;

	logic [reg_addr_w-1:0] rf_raddr1;
	logic [reg_addr_w-1:0] rf_raddr2;
	logic [xlen-1:0] rf_rdata1;
	logic [xlen-1:0] rf_rdata2;
	logic rf_wen;
	logic [reg_addr_w-1:0] rf_waddr;
	logic [xlen-1:0] rf_wdata;

	fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_i (
		.clk, .reset,
		.ireq_valid, .ireq_addr, .iresp_data_ok, .iresp_data,
		.f_valid, .f_pc, .f_instr
	);

	decode decode_i (
		.clk, .reset,
		.f_valid, .f_pc, .f_instr,
		.rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
		.d_valid, .d_pc, .d_instr, .d_alu_op, .d_a, .d_b, .d_wen, .d_wdest
	);

	regfile regfile_i (
		.clk, .reset,
		.raddr1(rf_raddr1), .raddr2(rf_raddr2),
		.rdata1(rf_rdata1), .rdata2(rf_rdata2),
		.wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	execute execute_i (
		.clk, .reset,
		.d_valid, .d_pc, .d_instr, .d_alu_op, .d_a, .d_b, .d_wen, .d_wdest,
		.e_valid, .e_pc, .e_instr, .e_wen, .e_wdest, .e_result
	);

	writeback writeback_i (
		.clk, .reset,
		.e_valid, .e_pc, .e_instr, .e_wen, .e_wdest, .e_result,
		.rf_wen, .rf_waddr, .rf_wdata,
		.commit_valid, .commit_pc, .commit_instr,
		.commit_wen, .commit_wdest, .commit_wdata
	);

endmodule

//--- core_pkg.sv
package core_pkg;

	// data and instruction widths.
	localparam int xlen = 64;
	localparam int ilen = 32;
	localparam int reg_addr_w = 5;

	localparam logic [xlen-1:0] default_reset_pc = 64'h8000_0000;

	// major opcodes of the supported subset.
	localparam logic [6:0] opcode_op_imm = 7'b0010011;
	localparam logic [6:0] opcode_op = 7'b0110011;
	localparam logic [6:0] opcode_lui = 7'b0110111;

	// funct7 values for register-register ops.
	localparam logic [6:0] funct7_base = 7'b0000000;
	localparam logic [6:0] funct7_alt = 7'b0100000;

	typedef enum logic [3:0] {
		op_addi,
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_slt,
		op_lui,
		op_invalid
	} op_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_t;

endpackage

//--- core_props.sv
module core_props (
	input logic clk,
	input logic reset,
	input logic ireq_valid,
	input logic commit_valid,
	input logic commit_wen,
	input logic [core_pkg::reg_addr_w-1:0] commit_wdest,
	input logic [core_pkg::xlen-1:0] commit_pc
);
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	ireq_valid_high: assert property (@(posedge clk) disable iff (reset) ireq_valid)
		else $error("ireq_valid low outside reset");

	wen_needs_valid: assert property (@(posedge clk) disable iff (reset)
		commit_wen |-> commit_valid)
		else $error("commit_wen without commit_valid");

	wen_not_x0: assert property (@(posedge clk) disable iff (reset)
		commit_wen |-> (commit_wdest != '0))
		else $error("commit_wen with x0 destination");

	pc_aligned: assert property (@(posedge clk) disable iff (reset)
		commit_valid |-> (commit_pc[1:0] == 2'b00))
		else $error("commit_pc not word aligned");

endmodule

bind core core_props core_props_i (
	.clk(clk),
	.reset(reset),
	.ireq_valid(ireq_valid),
	.commit_valid(commit_valid),
	.commit_wen(commit_wen),
	.commit_wdest(commit_wdest),
	.commit_pc(commit_pc)
);

//--- decode.sv
module decode (
	input  logic clk,
	input  logic reset,
	input  logic f_valid,
	input  logic [core_pkg::xlen-1:0] f_pc,
	input  logic [core_pkg::ilen-1:0] f_instr,
	output logic [core_pkg::reg_addr_w-1:0] rf_raddr1,
	output logic [core_pkg::reg_addr_w-1:0] rf_raddr2,
	input  logic [core_pkg::xlen-1:0] rf_rdata1,
	input  logic [core_pkg::xlen-1:0] rf_rdata2,
	output logic d_valid,
	output logic [core_pkg::xlen-1:0] d_pc,
	output logic [core_pkg::ilen-1:0] d_instr,
	output core_pkg::alu_op_t d_alu_op,
	output logic [core_pkg::xlen-1:0] d_a,
	output logic [core_pkg::xlen-1:0] d_b,
	output logic d_wen,
	output logic [core_pkg::reg_addr_w-1:0] d_wdest
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] b_sel;
	logic wen;
	op_t op;
	alu_op_t alu_op;

	assign opcode = f_instr[6:0];
	assign rd = f_instr[11:7];
	assign funct3 = f_instr[14:12];
	assign funct7 = f_instr[31:25];
	assign rf_raddr1 = f_instr[19:15];
	assign rf_raddr2 = f_instr[24:20];

	assign imm_i = {{(xlen-12){f_instr[31]}}, f_instr[31:20]};
	assign imm_u = {{(xlen-32){f_instr[31]}}, f_instr[31:12], 12'b0};

	always_comb begin
		op = op_invalid;
		case (opcode)
			opcode_op_imm: begin
				if (funct3 == 3'b000) op = op_addi;
			end
			opcode_op: begin
				case ({funct7, funct3})
					{funct7_base, 3'b000}: op = op_add;
					{funct7_alt, 3'b000}: op = op_sub;
					{funct7_base, 3'b111}: op = op_and;
					{funct7_base, 3'b110}: op = op_or;
					{funct7_base, 3'b100}: op = op_xor;
					{funct7_base, 3'b010}: op = op_slt;
					default: op = op_invalid;
				endcase
			end
			opcode_lui: op = op_lui;
			default: op = op_invalid;
		endcase
	end

	always_comb begin
		case (op)
			op_sub: alu_op = alu_sub;
			op_and: alu_op = alu_and;
			op_or: alu_op = alu_or;
			op_xor: alu_op = alu_xor;
			op_slt: alu_op = alu_slt;
			op_lui: alu_op = alu_pass_b;
			default: alu_op = alu_add; // addi, add, and dead invalid.
		endcase
	end

	always_comb begin
		case (op)
			op_addi: b_sel = imm_i;
			op_lui: b_sel = imm_u;
			default: b_sel = rf_rdata2;
		endcase
	end

	assign wen = (op != op_invalid) && (rd != '0); // x0 writes dropped.

	always_ff @(posedge clk) begin
		if (reset) begin
			d_valid <= 1'b0;
			d_wen <= 1'b0;
		end else begin
			d_valid <= f_valid;
			d_wen <= f_valid & wen;
		end
	end

	always_ff @(posedge clk) begin
		d_pc <= f_pc;
		d_instr <= f_instr;
		d_alu_op <= alu_op;
		d_a <= rf_rdata1;
		d_b <= b_sel;
		d_wdest <= rd;
	end

endmodule

//--- execute.sv
module execute (
	input  logic clk,
	input  logic reset,
	input  logic d_valid,
	input  logic [core_pkg::xlen-1:0] d_pc,
	input  logic [core_pkg::ilen-1:0] d_instr,
	input  core_pkg::alu_op_t d_alu_op,
	input  logic [core_pkg::xlen-1:0] d_a,
	input  logic [core_pkg::xlen-1:0] d_b,
	input  logic d_wen,
	input  logic [core_pkg::reg_addr_w-1:0] d_wdest,
	output logic e_valid,
	output logic [core_pkg::xlen-1:0] e_pc,
	output logic [core_pkg::ilen-1:0] e_instr,
	output logic e_wen,
	output logic [core_pkg::reg_addr_w-1:0] e_wdest,
	output logic [core_pkg::xlen-1:0] e_result
);
	import core_pkg::*;

	logic [xlen-1:0] result;
	logic lt;

	assign lt = $signed(d_a) < $signed(d_b); // signed compare for slt.

	always_comb begin
		case (d_alu_op)
			alu_add: result = d_a + d_b;
			alu_sub: result = d_a - d_b;
			alu_and: result = d_a & d_b;
			alu_or: result = d_a | d_b;
			alu_xor: result = d_a ^ d_b;
			alu_slt: result = {{(xlen-1){1'b0}}, lt};
			alu_pass_b: result = d_b; // lui.
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			e_valid <= 1'b0;
			e_wen <= 1'b0;
		end else begin
			e_valid <= d_valid;
			e_wen <= d_valid & d_wen;
		end
	end

	always_ff @(posedge clk) begin
		e_pc <= d_pc;
		e_instr <= d_instr;
		e_wdest <= d_wdest;
		e_result <= result;
	end

endmodule

//--- fetch_stage.sv
module fetch_stage #(
	parameter logic [core_pkg::xlen-1:0] RESET_PC = core_pkg::default_reset_pc
) (
	input  logic clk,
	input  logic reset,
	output logic ireq_valid,
	output logic [core_pkg::xlen-1:0] ireq_addr,
	input  logic iresp_data_ok,
	input  logic [core_pkg::ilen-1:0] iresp_data,
	output logic f_valid,
	output logic [core_pkg::xlen-1:0] f_pc,
	output logic [core_pkg::ilen-1:0] f_instr
);
	import core_pkg::*;

	logic [xlen-1:0] pc;
	logic accept;

	assign ireq_valid = 1'b1; // always requesting.
	assign ireq_addr = pc;
	assign accept = ireq_valid & iresp_data_ok;

	// no branches, so pc only steps by 4.
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (accept) begin
			pc <= pc + xlen'(4);
		end
	end

	// stall loads a bubble.
	always_ff @(posedge clk) begin
		if (reset) begin
			f_valid <= 1'b0;
		end else begin
			f_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		f_pc <= pc;
		f_instr <= iresp_data;
	end

endmodule

//--- regfile.sv
module regfile (
	input  logic clk,
	input  logic reset,
	input  logic [core_pkg::reg_addr_w-1:0] raddr1,
	input  logic [core_pkg::reg_addr_w-1:0] raddr2,
	output logic [core_pkg::xlen-1:0] rdata1,
	output logic [core_pkg::xlen-1:0] rdata2,
	input  logic wen,
	input  logic [core_pkg::reg_addr_w-1:0] waddr,
	input  logic [core_pkg::xlen-1:0] wdata
);
	import core_pkg::*;

	logic [xlen-1:0] regs [1:31]; // no storage for x0.

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
		if (addr == '0) return '0;
		else if (wen && addr == waddr) return wdata; // write-through.
		else return regs[addr];
	endfunction

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

endmodule

//--- tb_core.sv
module tb_core;
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	localparam logic [xlen-1:0] reset_pc = default_reset_pc;
	localparam int num_rows = 26;
	localparam int commit_timeout = 40;
	localparam logic [ilen-1:0] nop = 32'h0000_0013; // addi x0, x0, 0.

	logic clk;
	logic reset;
	logic ireq_valid;
	logic [xlen-1:0] ireq_addr;
	logic iresp_data_ok;
	logic [ilen-1:0] iresp_data;
	logic commit_valid;
	logic [xlen-1:0] commit_pc;
	logic [ilen-1:0] commit_instr;
	logic commit_wen;
	logic [reg_addr_w-1:0] commit_wdest;
	logic [xlen-1:0] commit_wdata;

	integer seed = 28660;

	logic [ilen-1:0] prog_instr [0:31];
	logic exp_wen [0:31];
	logic [reg_addr_w-1:0] exp_wdest [0:31];
	logic [xlen-1:0] exp_wdata [0:31];
	logic [xlen-1:0] fetch_offset;

	core #(.RESET_PC(reset_pc)) core_i (
		.clk, .reset,
		.ireq_valid, .ireq_addr, .iresp_data_ok, .iresp_data,
		.commit_valid, .commit_pc, .commit_instr,
		.commit_wen, .commit_wdest, .commit_wdata
	);

	always #50 clk = ~clk;

	// memory answers in the same cycle.
	always_comb begin
		fetch_offset = ireq_addr - reset_pc;
		if (fetch_offset < 64'(num_rows * 4)) begin
			iresp_data = prog_instr[fetch_offset[6:2]];
		end else begin
			iresp_data = nop;
		end
	end

	always @(posedge clk) begin
		iresp_data_ok <= ($random(seed) & 3) != 0; // stalls a quarter of the time.
	end

	function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] funct3, input logic [4:0] rd);
		return {imm, rs1, funct3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] encode_sw(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	task automatic set_row(input int row, input logic [31:0] instr, input logic wen,
			input logic [4:0] wdest, input logic [63:0] wdata);
		prog_instr[row] = instr;
		exp_wen[row] = wen;
		exp_wdest[row] = wdest;
		exp_wdata[row] = wdata;
	endtask

	// at least three rows between a producer and its consumer.
	task automatic load_table();
		set_row(0, encode_i(12'h005, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 64'h5);
		set_row(1, encode_i(12'hffd, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, 64'hffff_ffff_ffff_fffd);
		set_row(2, encode_u(20'h80000, 5'd3), 1'b1, 5'd3, 64'hffff_ffff_8000_0000);
		set_row(3, encode_u(20'h12345, 5'd4), 1'b1, 5'd4, 64'h0000_0000_1234_5000);
		set_row(4, encode_r(7'h20, 5'd1, 5'd0, 3'b000, 5'd7), 1'b1, 5'd7, 64'hffff_ffff_ffff_fffb);
		set_row(5, encode_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd6), 1'b1, 5'd6, 64'h8);
		set_row(6, encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 1'b1, 5'd5, 64'h2);
		set_row(7, encode_r(7'h00, 5'd4, 5'd2, 3'b111, 5'd8), 1'b1, 5'd8, 64'h0000_0000_1234_5000);
		set_row(8, encode_r(7'h00, 5'd3, 5'd1, 3'b110, 5'd9), 1'b1, 5'd9, 64'hffff_ffff_8000_0005);
		set_row(9, encode_r(7'h00, 5'd3, 5'd2, 3'b100, 5'd10), 1'b1, 5'd10, 64'h0000_0000_7fff_fffd);
		set_row(10, encode_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd11), 1'b1, 5'd11, 64'h1);
		set_row(11, encode_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd12), 1'b1, 5'd12, 64'h0);
		set_row(12, encode_r(7'h00, 5'd4, 5'd3, 3'b010, 5'd13), 1'b1, 5'd13, 64'h1);
		set_row(13, encode_i(12'h007, 5'd1, 3'b000, 5'd0), 1'b0, 5'd0, 64'h0); // x0 target.
		set_row(14, encode_sw(5'd1, 5'd2, 12'h000), 1'b0, 5'd0, 64'h0); // unsupported.
		set_row(15, encode_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0), 1'b0, 5'd0, 64'h0);
		set_row(16, nop, 1'b0, 5'd0, 64'h0);
		set_row(17, encode_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd14), 1'b1, 5'd14, 64'h5);
		set_row(18, encode_i(12'h001, 5'd1, 3'b000, 5'd1), 1'b1, 5'd1, 64'h6);
		set_row(19, encode_i(12'hfff, 5'd5, 3'b000, 5'd15), 1'b1, 5'd15, 64'h1);
		set_row(20, nop, 1'b0, 5'd0, 64'h0);
		set_row(21, nop, 1'b0, 5'd0, 64'h0);
		set_row(22, encode_r(7'h00, 5'd6, 5'd1, 3'b000, 5'd16), 1'b1, 5'd16, 64'he);
		set_row(23, encode_r(7'h20, 5'd2, 5'd0, 3'b000, 5'd17), 1'b1, 5'd17, 64'h3);
		set_row(24, encode_i(12'h7ff, 5'd0, 3'b000, 5'd18), 1'b1, 5'd18, 64'h7ff);
		set_row(25, encode_i(12'h800, 5'd0, 3'b000, 5'd19), 1'b1, 5'd19, 64'hffff_ffff_ffff_f800);
	endtask

	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		assert (got == expected) else begin
			$display("MISMATCH %s: expected %h, got %h", name, expected, got);
			stop_with_failure();
		end
	endtask

	task automatic wait_for_commit(input int row);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!commit_valid && cycles < commit_timeout);
		assert (commit_valid) else begin
			$display("timeout: row %0d did not commit within %0d cycles", row, commit_timeout);
			stop_with_failure();
		end
	endtask

	task automatic check_row(input int row);
		logic [xlen-1:0] exp_pc;
		exp_pc = reset_pc + 64'(row * 4);
		check_value("commit_pc", commit_pc, exp_pc);
		check_value("commit_instr", 64'(commit_instr), 64'(prog_instr[row]));
		check_value("commit_wen", 64'(commit_wen), 64'(exp_wen[row]));
		if (exp_wen[row]) begin
			check_value("commit_wdest", 64'(commit_wdest), 64'(exp_wdest[row]));
			check_value("commit_wdata", commit_wdata, exp_wdata[row]);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		iresp_data_ok = 1'b0;
		load_table();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("ireq_addr", ireq_addr, reset_pc);
		check_value("commit_valid", 64'(commit_valid), 64'h0);
		for (int row = 0; row < num_rows; row++) begin
			wait_for_commit(row); // one negedge per step, so each commit is seen once.
			check_row(row);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- verilog.f
core_pkg.sv
fetch_stage.sv
decode.sv
regfile.sv
execute.sv
writeback.sv
core.sv
core_props.sv
tb_core.sv

//--- writeback.sv
module writeback (
	input  logic clk,
	input  logic reset,
	input  logic e_valid,
	input  logic [core_pkg::xlen-1:0] e_pc,
	input  logic [core_pkg::ilen-1:0] e_instr,
	input  logic e_wen,
	input  logic [core_pkg::reg_addr_w-1:0] e_wdest,
	input  logic [core_pkg::xlen-1:0] e_result,
	output logic rf_wen,
	output logic [core_pkg::reg_addr_w-1:0] rf_waddr,
	output logic [core_pkg::xlen-1:0] rf_wdata,
	output logic commit_valid,
	output logic [core_pkg::xlen-1:0] commit_pc,
	output logic [core_pkg::ilen-1:0] commit_instr,
	output logic commit_wen,
	output logic [core_pkg::reg_addr_w-1:0] commit_wdest,
	output logic [core_pkg::xlen-1:0] commit_wdata
);

	// commit ports are the writeback register itself.
	always_ff @(posedge clk) begin
		if (reset) begin
			commit_valid <= 1'b0;
			commit_wen <= 1'b0;
		end else begin
			commit_valid <= e_valid;
			commit_wen <= e_valid & e_wen;
		end
	end

	always_ff @(posedge clk) begin
		commit_pc <= e_pc;
		commit_instr <= e_instr;
		commit_wdest <= e_wdest;
		commit_wdata <= e_result;
	end

	assign rf_wen = commit_valid & commit_wen; // lands on the next edge.
	assign rf_waddr = commit_wdest;
	assign rf_wdata = commit_wdata;

endmodule
